// File: common/qrd_defines.svh
`ifndef QRD_DEFINES_SVH
`define QRD_DEFINES_SVH

// sample width, shared by the row input, the array and R
`define QRD_WIDTH 14

// fraction bits of the gain, Q.10
`define QRD_FRAC 10

// micro-rotations per beat
`define QRD_NUM_ITER 12

// 1 load cycle, 12 rotate cycles and 1 scale cycle
`define QRD_BEAT_LEN 14

// matrix size
`define QRD_N 3

`endif

// File: common/qrd_pkg.sv
`default_nettype none

`include "qrd_defines.svh"

package qrd_pkg;

    typedef logic signed [`QRD_WIDTH-1:0] sample_t;

    typedef logic [3:0] iter_t;

    typedef logic [3:0] rot_cnt_t;

    // unsigned Q.10, 1024 is unity
    typedef logic [`QRD_FRAC:0] gain_t;

    typedef logic signed [`QRD_WIDTH+`QRD_FRAC:0] prod_t;

    typedef enum logic [1:0] {
        PH_LOAD,
        PH_ROTATE,
        PH_SCALE
    } beat_phase_e;

    // inverse CORDIC gain for the number of rotations actually done
    function automatic gain_t gain_for_count(rot_cnt_t cnt);
        gain_t g;
        case (cnt)
            4'd0: g = 11'd1024;
            4'd1: g = 11'd724;
            4'd2: g = 11'd648;
            4'd3: g = 11'd628;
            4'd4: g = 11'd623;
            default: g = 11'd622;
        endcase
        return g;
    endfunction

endpackage

`default_nettype wire

// File: hw/beat_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "qrd_defines.svh"

module beat_sequencer (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     row_valid_i,
    output logic                    in_ready_o,
    output logic                    out_valid_o,
    output qrd_pkg::beat_phase_e    phase_o,
    output qrd_pkg::iter_t          iter_o,
    output logic [`QRD_N-1:0]       stage_valid_o,
    output logic [`QRD_N-1:0]       stage_first_o,
    output logic [`QRD_N-1:0]       stage_last_o
);

    logic [3:0] beat_cnt;
    logic [1:0] row_cnt;
    logic       beat_end;
    logic       row_first;
    logic       row_last;

    assign beat_end  = beat_cnt == 4'(`QRD_BEAT_LEN - 1);
    assign row_first = row_valid_i && (row_cnt == 2'd0);
    assign row_last  = row_valid_i && (row_cnt == 2'(`QRD_N - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (beat_end) begin
            beat_cnt <= '0;
        end else begin
            beat_cnt <= beat_cnt + 4'd1;
        end
    end

    // cycle 0 loads, cycles 1..12 rotate, the last cycle scales
    always_comb begin
        if (beat_cnt == 4'd0) begin
            phase_o = qrd_pkg::PH_LOAD;
        end else if (beat_end) begin
            phase_o = qrd_pkg::PH_SCALE;
        end else begin
            phase_o = qrd_pkg::PH_ROTATE;
        end
    end

    assign iter_o = (phase_o == qrd_pkg::PH_ROTATE) ? qrd_pkg::iter_t'(beat_cnt - 4'd1) : '0;

    // input is taken in the scale cycle, as the tags move down
    assign in_ready_o = beat_end;

    // only real rows advance the position within the matrix
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_cnt <= '0;
        end else if (beat_end && row_valid_i) begin
            row_cnt <= row_last ? 2'd0 : row_cnt + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_valid_o <= '0;
            stage_first_o <= '0;
            stage_last_o  <= '0;
        end else if (beat_end) begin
            stage_valid_o <= {stage_valid_o[`QRD_N-2:0], row_valid_i};
            stage_first_o <= {stage_first_o[`QRD_N-2:0], row_first};
            stage_last_o  <= {stage_last_o[`QRD_N-2:0], row_last};
        end
    end

    // R is complete once the closing row leaves the bottom array row
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= beat_end && stage_last_o[`QRD_N-1];
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) in_ready_o |=> !in_ready_o);

endmodule

`default_nettype wire

// File: array/cordic_step.sv
`timescale 1ns/10ps
`default_nettype none

`include "qrd_defines.svh"

module cordic_step (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire qrd_pkg::beat_phase_e   phase_i,
    input  wire qrd_pkg::iter_t         iter_i,
    input  wire qrd_pkg::sample_t       load_x_i,
    input  wire qrd_pkg::sample_t       load_y_i,
    input  wire                         dir_i,
    input  wire                         rot_en_i,
    output qrd_pkg::sample_t            x_o,
    output qrd_pkg::sample_t            y_o
);

    localparam int W = `QRD_WIDTH;

    // arithmetic shift right in four stages, 1/2/4/8
    function automatic qrd_pkg::sample_t shift_right(qrd_pkg::sample_t v, qrd_pkg::iter_t s);
        qrd_pkg::sample_t t;
        t = v;
        if (s[0]) t = {t[W-1], t[W-1:1]};
        if (s[1]) t = {{2{t[W-1]}}, t[W-1:2]};
        if (s[2]) t = {{4{t[W-1]}}, t[W-1:4]};
        if (s[3]) t = {{8{t[W-1]}}, t[W-1:8]};
        return t;
    endfunction

    qrd_pkg::sample_t   x_q;
    qrd_pkg::sample_t   y_q;
    qrd_pkg::rot_cnt_t  cnt_q;
    qrd_pkg::sample_t   x_sh;
    qrd_pkg::sample_t   y_sh;
    qrd_pkg::gain_t     gain;
    qrd_pkg::prod_t     x_prod;
    qrd_pkg::prod_t     y_prod;

    assign x_sh = shift_right(x_q, iter_i);
    assign y_sh = shift_right(y_q, iter_i);

    always_ff @(posedge clk) begin
        if (phase_i == qrd_pkg::PH_LOAD) begin
            x_q <= load_x_i;
            y_q <= load_y_i;
        end else if (phase_i == qrd_pkg::PH_ROTATE && rot_en_i) begin
            if (dir_i) begin
                x_q <= x_q + y_sh;
                y_q <= y_q - x_sh;
            end else begin
                x_q <= x_q - y_sh;
                y_q <= y_q + x_sh;
            end
        end
    end

    // skipped micro-rotations add no gain, so only performed ones count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (phase_i == qrd_pkg::PH_LOAD) begin
            cnt_q <= '0;
        end else if (phase_i == qrd_pkg::PH_ROTATE && rot_en_i) begin
            cnt_q <= cnt_q + 4'd1;
        end
    end

    assign gain   = qrd_pkg::gain_for_count(cnt_q);
    assign x_prod = qrd_pkg::prod_t'(x_q) * qrd_pkg::prod_t'(gain);
    assign y_prod = qrd_pkg::prod_t'(y_q) * qrd_pkg::prod_t'(gain);

    // live values while rotating, compensated values in the scale cycle
    assign x_o = (phase_i == qrd_pkg::PH_SCALE) ? x_prod[W+`QRD_FRAC-1:`QRD_FRAC] : x_q;
    assign y_o = (phase_i == qrd_pkg::PH_SCALE) ? y_prod[W+`QRD_FRAC-1:`QRD_FRAC] : y_q;

    assert property (@(posedge clk) disable iff (!rst_n) cnt_q <= `QRD_NUM_ITER);

endmodule

`default_nettype wire

// File: array/boundary_cell.sv
`timescale 1ns/10ps
`default_nettype none

module boundary_cell (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire qrd_pkg::beat_phase_e   phase_i,
    input  wire qrd_pkg::iter_t         iter_i,
    input  wire                         valid_i,
    input  wire                         first_i,
    input  wire                         last_i,
    input  wire qrd_pkg::sample_t       a_i,
    output logic                        dir_o,
    output logic                        rot_en_o,
    output qrd_pkg::sample_t            r_o
);

    // diagonal r accumulated over the rows of the current matrix
    qrd_pkg::sample_t r_q;
    qrd_pkg::sample_t load_x;
    qrd_pkg::sample_t x_val;
    qrd_pkg::sample_t y_val;

    // first row of a matrix starts from an empty diagonal
    assign load_x = first_i ? '0 : r_q;

    cordic_step u_step (
        .clk      (clk),
        .rst_n    (rst_n),
        .phase_i  (phase_i),
        .iter_i   (iter_i),
        .load_x_i (load_x),
        .load_y_i (a_i),
        .dir_i    (dir_o),
        .rot_en_i (rot_en_o),
        .x_o      (x_val),
        .y_o      (y_val)
    );

    // vectoring drives y toward zero and stops once it gets there
    assign rot_en_o = (phase_i == qrd_pkg::PH_ROTATE) && (y_val != '0);
    assign dir_o    = y_val > 0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_q <= '0;
        end else if (phase_i == qrd_pkg::PH_SCALE && valid_i) begin
            r_q <= x_val;
        end
    end

    // held until the next matrix closes here
    always_ff @(posedge clk) begin
        if (phase_i == qrd_pkg::PH_SCALE && valid_i && last_i) begin
            r_o <= x_val;
        end
    end

endmodule

`default_nettype wire

// File: array/internal_cell.sv
`timescale 1ns/10ps
`default_nettype none

module internal_cell (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire qrd_pkg::beat_phase_e   phase_i,
    input  wire qrd_pkg::iter_t         iter_i,
    input  wire                         valid_i,
    input  wire                         first_i,
    input  wire                         last_i,
    input  wire qrd_pkg::sample_t       a_i,
    input  wire                         dir_i,
    input  wire                         rot_en_i,
    output qrd_pkg::sample_t            y_o,
    output qrd_pkg::sample_t            r_o
);

    qrd_pkg::sample_t r_q;
    qrd_pkg::sample_t load_x;
    qrd_pkg::sample_t x_val;
    qrd_pkg::sample_t y_val;

    assign load_x = first_i ? '0 : r_q;

    // rotates in lockstep with the boundary cell of this array row
    cordic_step u_step (
        .clk      (clk),
        .rst_n    (rst_n),
        .phase_i  (phase_i),
        .iter_i   (iter_i),
        .load_x_i (load_x),
        .load_y_i (a_i),
        .dir_i    (dir_i),
        .rot_en_i (rot_en_i),
        .x_o      (x_val),
        .y_o      (y_val)
    );

    // y_o is the pipeline register toward the array row below
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_q <= '0;
            y_o <= '0;
        end else if (phase_i == qrd_pkg::PH_SCALE && valid_i) begin
            r_q <= x_val;
            y_o <= y_val;
        end
    end

    always_ff @(posedge clk) begin
        if (phase_i == qrd_pkg::PH_SCALE && valid_i && last_i) begin
            r_o <= x_val;
        end
    end

endmodule

`default_nettype wire

// File: hw/qrd_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "qrd_defines.svh"

module qrd_top (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     row_valid_i,
    input  wire  qrd_pkg::sample_t  a_0_i,
    input  wire  qrd_pkg::sample_t  a_1_i,
    input  wire  qrd_pkg::sample_t  a_2_i,
    output logic                    in_ready_o,
    output logic                    out_valid_o,
    output qrd_pkg::sample_t        r_00_o,
    output qrd_pkg::sample_t        r_01_o,
    output qrd_pkg::sample_t        r_02_o,
    output qrd_pkg::sample_t        r_11_o,
    output qrd_pkg::sample_t        r_12_o,
    output qrd_pkg::sample_t        r_22_o
);

    qrd_pkg::beat_phase_e   phase;
    qrd_pkg::iter_t         iter;
    logic [`QRD_N-1:0]      stage_valid;
    logic [`QRD_N-1:0]      stage_first;
    logic [`QRD_N-1:0]      stage_last;

    // sampled input row, feeds array row 0 during the next beat
    qrd_pkg::sample_t       a_q_0;
    qrd_pkg::sample_t       a_q_1;
    qrd_pkg::sample_t       a_q_2;

    // direction broadcast of array rows 0 and 1
    logic [1:0]             dir;
    logic [1:0]             rot_en;

    // remainders handed down between array rows
    qrd_pkg::sample_t       y_01;
    qrd_pkg::sample_t       y_02;
    qrd_pkg::sample_t       y_12;

    beat_sequencer u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .row_valid_i   (row_valid_i),
        .in_ready_o    (in_ready_o),
        .out_valid_o   (out_valid_o),
        .phase_o       (phase),
        .iter_o        (iter),
        .stage_valid_o (stage_valid),
        .stage_first_o (stage_first),
        .stage_last_o  (stage_last)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_q_0 <= '0;
            a_q_1 <= '0;
            a_q_2 <= '0;
        end else if (in_ready_o && row_valid_i) begin
            a_q_0 <= a_0_i;
            a_q_1 <= a_1_i;
            a_q_2 <= a_2_i;
        end
    end

    boundary_cell u_b00 (
        .clk(clk), .rst_n(rst_n), .phase_i(phase), .iter_i(iter),
        .valid_i(stage_valid[0]), .first_i(stage_first[0]), .last_i(stage_last[0]),
        .a_i(a_q_0), .dir_o(dir[0]), .rot_en_o(rot_en[0]), .r_o(r_00_o)
    );

    internal_cell u_i01 (
        .clk(clk), .rst_n(rst_n), .phase_i(phase), .iter_i(iter),
        .valid_i(stage_valid[0]), .first_i(stage_first[0]), .last_i(stage_last[0]),
        .a_i(a_q_1), .dir_i(dir[0]), .rot_en_i(rot_en[0]), .y_o(y_01), .r_o(r_01_o)
    );

    internal_cell u_i02 (
        .clk(clk), .rst_n(rst_n), .phase_i(phase), .iter_i(iter),
        .valid_i(stage_valid[0]), .first_i(stage_first[0]), .last_i(stage_last[0]),
        .a_i(a_q_2), .dir_i(dir[0]), .rot_en_i(rot_en[0]), .y_o(y_02), .r_o(r_02_o)
    );

    boundary_cell u_b11 (
        .clk(clk), .rst_n(rst_n), .phase_i(phase), .iter_i(iter),
        .valid_i(stage_valid[1]), .first_i(stage_first[1]), .last_i(stage_last[1]),
        .a_i(y_01), .dir_o(dir[1]), .rot_en_o(rot_en[1]), .r_o(r_11_o)
    );

    internal_cell u_i12 (
        .clk(clk), .rst_n(rst_n), .phase_i(phase), .iter_i(iter),
        .valid_i(stage_valid[1]), .first_i(stage_first[1]), .last_i(stage_last[1]),
        .a_i(y_02), .dir_i(dir[1]), .rot_en_i(rot_en[1]), .y_o(y_12), .r_o(r_12_o)
    );

    // last array row has no internal cell to steer
    boundary_cell u_b22 (
        .clk(clk), .rst_n(rst_n), .phase_i(phase), .iter_i(iter),
        .valid_i(stage_valid[2]), .first_i(stage_first[2]), .last_i(stage_last[2]),
        .a_i(y_12), .dir_o(), .rot_en_o(), .r_o(r_22_o)
    );

endmodule

`default_nettype wire

// File: bench/qrd_model.svh
`ifndef QRD_MODEL_SVH
`define QRD_MODEL_SVH

// cell registers of the reference array, one array row at a time
qrd_pkg::sample_t cell_x [3];
qrd_pkg::sample_t cell_y [3];

// r00 r01 r02 r11 r12 r22
qrd_pkg::sample_t model_r [6];

// Q.10 inverse CORDIC gain for the number of rotations done
function automatic int inv_gain(input int cnt);
    int g;
    case (cnt)
        0: g = 1024;
        1: g = 724;
        2: g = 648;
        3: g = 628;
        4: g = 623;
        default: g = 622;
    endcase
    return g;
endfunction

function automatic qrd_pkg::sample_t scale_q10(input qrd_pkg::sample_t v, input int g);
    longint p;
    p = longint'(v) * longint'(g);
    return qrd_pkg::sample_t'(p >>> `QRD_FRAC);
endfunction

// cell 0 vectors, cells 1..n-1 follow its directions
task automatic rotate_cells(input int n);
    qrd_pkg::sample_t x_old;
    qrd_pkg::sample_t y_old;
    bit up;
    int cnt;
    int i;
    int c;
    cnt = 0;
    for (i = 0; i < `QRD_NUM_ITER; i++) begin
        if (cell_y[0] != '0) begin
            up = !cell_y[0][`QRD_WIDTH-1];
            for (c = 0; c < n; c++) begin
                x_old = cell_x[c];
                y_old = cell_y[c];
                if (up) begin
                    cell_x[c] = x_old + (y_old >>> i);
                    cell_y[c] = y_old - (x_old >>> i);
                end else begin
                    cell_x[c] = x_old - (y_old >>> i);
                    cell_y[c] = y_old + (x_old >>> i);
                end
            end
            cnt++;
        end
    end
    for (c = 0; c < n; c++) begin
        cell_x[c] = scale_q10(cell_x[c], inv_gain(cnt));
        cell_y[c] = scale_q10(cell_y[c], inv_gain(cnt));
    end
endtask

// pushes one valid row through all three array rows
task automatic model_row(input qrd_pkg::sample_t a0, input qrd_pkg::sample_t a1,
                         input qrd_pkg::sample_t a2, input bit first);
    qrd_pkg::sample_t rem_1;
    qrd_pkg::sample_t rem_2;
    cell_x[0] = first ? '0 : model_r[0];
    cell_x[1] = first ? '0 : model_r[1];
    cell_x[2] = first ? '0 : model_r[2];
    cell_y[0] = a0;
    cell_y[1] = a1;
    cell_y[2] = a2;
    rotate_cells(3);
    model_r[0] = cell_x[0];
    model_r[1] = cell_x[1];
    model_r[2] = cell_x[2];
    rem_1 = cell_y[1];
    rem_2 = cell_y[2];
    cell_x[0] = first ? '0 : model_r[3];
    cell_x[1] = first ? '0 : model_r[4];
    cell_y[0] = rem_1;
    cell_y[1] = rem_2;
    rotate_cells(2);
    model_r[3] = cell_x[0];
    model_r[4] = cell_x[1];
    cell_x[0] = first ? '0 : model_r[5];
    cell_y[0] = cell_y[1];
    rotate_cells(1);
    model_r[5] = cell_x[0];
endtask

`endif

// File: bench/qrd_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "qrd_defines.svh"

module qrd_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int OUT_LATENCY  = 42;
    localparam int B2B_MATS     = 8;
    localparam int BUBBLE_MATS  = 6;
    localparam int ZERO_MATS    = 2;
    localparam int EXTREME_MATS = 4;
    // a matrix with bubbles can take up to six beats
    localparam int RUN_BEATS =
        `QRD_N * (B2B_MATS + 2 * BUBBLE_MATS + ZERO_MATS + EXTREME_MATS) + 8;

    typedef struct {
        int                 due;
        string              name;
        qrd_pkg::sample_t   r00;
        qrd_pkg::sample_t   r01;
        qrd_pkg::sample_t   r02;
        qrd_pkg::sample_t   r11;
        qrd_pkg::sample_t   r12;
        qrd_pkg::sample_t   r22;
    } expect_t;

    logic               clk;
    logic               rst_n;
    logic               row_valid_i;
    qrd_pkg::sample_t   a_0_i;
    qrd_pkg::sample_t   a_1_i;
    qrd_pkg::sample_t   a_2_i;
    logic               in_ready_o;
    logic               out_valid_o;
    qrd_pkg::sample_t   r_00_o;
    qrd_pkg::sample_t   r_01_o;
    qrd_pkg::sample_t   r_02_o;
    qrd_pkg::sample_t   r_11_o;
    qrd_pkg::sample_t   r_12_o;
    qrd_pkg::sample_t   r_22_o;

    logic               running;
    int                 cyc;
    expect_t            exp_q [$];

    `include "qrd_model.svh"

    qrd_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .row_valid_i (row_valid_i),
        .a_0_i       (a_0_i),
        .a_1_i       (a_1_i),
        .a_2_i       (a_2_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .r_00_o      (r_00_o),
        .r_01_o      (r_01_o),
        .r_02_o      (r_02_o),
        .r_11_o      (r_11_o),
        .r_12_o      (r_12_o),
        .r_22_o      (r_22_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // counts cycles since reset release
    // cycle 13 of each beat takes the row
    always @(posedge clk) begin
        running <= rst_n;
        if (!rst_n) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_sample(input string name, input qrd_pkg::sample_t exp,
                                input qrd_pkg::sample_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s: expected %0b, actual %0b", name, exp, act));
        end
    endtask

    // kind 0 random, 1 zero first column, 2 full scale with random sign
    function automatic qrd_pkg::sample_t pick_element(input int kind, input int col);
        qrd_pkg::sample_t v;
        v = qrd_pkg::sample_t'(int'($urandom % 32'd2047) - 1023);
        if (kind == 1 && col == 0) begin
            v = '0;
        end else if (kind == 2) begin
            v = v[`QRD_WIDTH-1] ? qrd_pkg::sample_t'(-1023) : qrd_pkg::sample_t'(1023);
        end
        return v;
    endfunction

    // noise outside the ready cycle must be ignored by the DUT
    task automatic feed_row(input bit valid, input qrd_pkg::sample_t a0,
                            input qrd_pkg::sample_t a1, input qrd_pkg::sample_t a2);
        @(negedge clk);
        while ((cyc % `QRD_BEAT_LEN) != `QRD_BEAT_LEN - 1) begin
            row_valid_i = 1'($urandom & 32'd1);
            a_0_i = pick_element(0, 0);
            a_1_i = pick_element(0, 1);
            a_2_i = pick_element(0, 2);
            @(negedge clk);
        end
        row_valid_i = valid;
        a_0_i = a0;
        a_1_i = a1;
        a_2_i = a2;
    endtask

    task automatic feed_matrix(input string name, input int kind, input bit bubbles);
        qrd_pkg::sample_t a0;
        qrd_pkg::sample_t a1;
        qrd_pkg::sample_t a2;
        expect_t e;
        int m;
        for (m = 0; m < `QRD_N; m++) begin
            if (bubbles && ($urandom % 32'd3) == 32'd0) begin
                feed_row(1'b0, pick_element(0, 0), pick_element(0, 1), pick_element(0, 2));
            end
            a0 = pick_element(kind, 0);
            a1 = pick_element(kind, 1);
            a2 = pick_element(kind, 2);
            feed_row(1'b1, a0, a1, a2);
            model_row(a0, a1, a2, m == 0);
        end
        // the closing row is sampled at the rising edge that ends this cycle
        e.due = cyc + 1 + OUT_LATENCY;
        e.name = name;
        e.r00 = model_r[0];
        e.r01 = model_r[1];
        e.r02 = model_r[2];
        e.r11 = model_r[3];
        e.r12 = model_r[4];
        e.r22 = model_r[5];
        exp_q.push_back(e);
    endtask

    // outputs only change on the rising edge
    always @(negedge clk) begin
        if (running) begin
            check_flag("in_ready_o", (cyc % `QRD_BEAT_LEN) == `QRD_BEAT_LEN - 1, in_ready_o);
            if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
                check_flag({exp_q[0].name, " out_valid_o"}, 1'b1, out_valid_o);
                check_sample({exp_q[0].name, " r_00_o"}, exp_q[0].r00, r_00_o);
                check_sample({exp_q[0].name, " r_01_o"}, exp_q[0].r01, r_01_o);
                check_sample({exp_q[0].name, " r_02_o"}, exp_q[0].r02, r_02_o);
                check_sample({exp_q[0].name, " r_11_o"}, exp_q[0].r11, r_11_o);
                check_sample({exp_q[0].name, " r_12_o"}, exp_q[0].r12, r_12_o);
                check_sample({exp_q[0].name, " r_22_o"}, exp_q[0].r22, r_22_o);
                check_flag({exp_q[0].name, " diagonal sign"}, 1'b0,
                           r_00_o[`QRD_WIDTH-1] | r_11_o[`QRD_WIDTH-1] | r_22_o[`QRD_WIDTH-1]);
                exp_q.delete(0);
            end else begin
                check_flag("out_valid_o", 1'b0, out_valid_o);
            end
        end
    end

    initial begin
        #(RUN_BEATS * `QRD_BEAT_LEN * CLK_PERIOD);
        abort_run("timeout: the run took longer than the tests allow");
    end

    initial begin
        int t;
        void'($urandom(32'hc921_9283));
        clk = 1'b0;
        rst_n = 1'b0;
        row_valid_i = 1'b0;
        a_0_i = '0;
        a_1_i = '0;
        a_2_i = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (t = 0; t < B2B_MATS; t++) begin
            feed_matrix("back_to_back", 0, 1'b0);
        end
        for (t = 0; t < BUBBLE_MATS; t++) begin
            feed_matrix("bubbles", 0, 1'b1);
        end
        for (t = 0; t < ZERO_MATS; t++) begin
            feed_matrix("zero_column", 1, 1'b0);
        end
        for (t = 0; t < EXTREME_MATS; t++) begin
            feed_matrix("extreme", 2, 1'b0);
        end
        while (exp_q.size() != 0) begin
            @(negedge clk);
            row_valid_i = 1'b0;
        end
        // out_valid_o has to stay low over two idle beats
        repeat (2 * `QRD_BEAT_LEN) @(negedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: qrd_top.f
+incdir+common
+incdir+bench
common/qrd_pkg.sv
hw/beat_sequencer.sv
array/cordic_step.sv
array/boundary_cell.sv
array/internal_cell.sv
hw/qrd_top.sv
bench/qrd_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module qrd_tb -f qrd_top.f -o qrd_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/qrd_sim > sim.log 2>&1
cat sim.log

grep -q "TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "simulation ended without result"; exit 1; }
exit 0
